/* hdl/link_cache_pkg.sv */
package link_cache_pkg;

  localparam int data_width_c = 32;
  localparam int mask_width_c = data_width_c / 8;
  // network word address, bit 15 picks the tag region
  localparam int addr_width_c = 16;
  // byte address seen by the store, region bit dropped
  localparam int cache_addr_width_c = addr_width_c + 1;
  localparam int tag_width_c = 16;
  localparam int id_width_c = 6;

  typedef enum logic [2:0] {
    e_store,
    e_store_word,
    e_load,
    e_amoswap,
    e_amoor,
    e_amoadd
  } net_op_e;

  typedef enum logic [1:0] {
    e_size_word,
    e_size_half,
    e_size_byte
  } load_size_e;

  typedef enum logic [3:0] {
    LW,
    LH,
    LHU,
    LB,
    LBU,
    SM,
    AMOSWAP_W,
    AMOOR_W,
    AMOADD_W,
    TAGST,
    TAGLA
  } cache_op_e;

  typedef enum logic [1:0] {
    e_ret_credit,
    e_ret_int_wb,
    e_ret_ifetch
  } ret_type_e;

  typedef enum logic [1:0] {
    e_region_data,
    e_region_tag,
    e_region_route
  } addr_region_e;

  typedef enum logic [1:0] {
    e_state_reset,
    e_state_clear_tag,
    e_state_ready,
    e_state_ifetch
  } link_state_e;

endpackage

/* hdl/request_fifo.sv */
module request_fifo #(
  parameter int FIFO_ELS_P = 4
) (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  link_cache_pkg::net_op_e                   req_op_i,
  input  logic [link_cache_pkg::addr_width_c-1:0]   req_addr_i,
  input  logic [link_cache_pkg::data_width_c-1:0]   req_data_i,
  input  logic [link_cache_pkg::mask_width_c-1:0]   req_mask_i,
  input  link_cache_pkg::load_size_e                req_size_i,
  input  logic                                      req_unsigned_i,
  input  logic                                      req_ifetch_i,
  input  logic [link_cache_pkg::id_width_c-1:0]     req_id_i,
  input  logic                                      v_i,
  output logic                                      ready_o,
  output link_cache_pkg::net_op_e                   pkt_op_o,
  output logic [link_cache_pkg::addr_width_c-1:0]   pkt_addr_o,
  output logic [link_cache_pkg::data_width_c-1:0]   pkt_data_o,
  output logic [link_cache_pkg::mask_width_c-1:0]   pkt_mask_o,
  output link_cache_pkg::load_size_e                pkt_size_o,
  output logic                                      pkt_unsigned_o,
  output logic                                      pkt_ifetch_o,
  output logic [link_cache_pkg::id_width_c-1:0]     pkt_id_o,
  output logic                                      v_o,
  input  logic                                      yumi_i
);
  localparam int op_w_lp = $bits(link_cache_pkg::net_op_e);
  localparam int size_w_lp = $bits(link_cache_pkg::load_size_e);
  localparam int entry_w_lp = op_w_lp + size_w_lp + link_cache_pkg::addr_width_c
    + link_cache_pkg::data_width_c + link_cache_pkg::mask_width_c
    + link_cache_pkg::id_width_c + 2;
  localparam int ptr_w_lp = $clog2(FIFO_ELS_P);

  logic [entry_w_lp-1:0] mem [FIFO_ELS_P];
  logic [ptr_w_lp-1:0] wptr_r, rptr_r;
  logic [ptr_w_lp:0] count_r, count_n;
  logic ready_r;
  logic push, pop;
  logic [op_w_lp-1:0] rd_op;
  logic [size_w_lp-1:0] rd_size;

  assign push = v_i & ready_o;
  assign pop = yumi_i;
  assign count_n = count_r + push - pop;
  assign ready_o = ready_r;
  assign v_o = (count_r != '0);

  assign {rd_op, pkt_addr_o, pkt_data_o, pkt_mask_o, rd_size, pkt_unsigned_o,
          pkt_ifetch_o, pkt_id_o} = mem[rptr_r];
  assign pkt_op_o = link_cache_pkg::net_op_e'(rd_op);
  assign pkt_size_o = link_cache_pkg::load_size_e'(rd_size);

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr_r] <= {req_op_i, req_addr_i, req_data_i, req_mask_i, req_size_i,
                      req_unsigned_i, req_ifetch_i, req_id_i};
    end
  end

  // ready is registered so it stays low through reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
      ready_r <= 1'b0;
    end else begin
      if (push) wptr_r <= (wptr_r == FIFO_ELS_P - 1) ? '0 : wptr_r + 1'b1;
      if (pop) rptr_r <= (rptr_r == FIFO_ELS_P - 1) ? '0 : rptr_r + 1'b1;
      count_r <= count_n;
      ready_r <= (count_n != FIFO_ELS_P);
    end
  end

endmodule

/* hdl/link_to_cache.sv */
module link_to_cache #(
  parameter int SETS_P = 8,
  parameter int BLOCK_WORDS_P = 4
) (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  link_cache_pkg::net_op_e                       pkt_op_i,
  input  logic [link_cache_pkg::addr_width_c-1:0]       pkt_addr_i,
  input  logic [link_cache_pkg::data_width_c-1:0]       pkt_data_i,
  input  logic [link_cache_pkg::mask_width_c-1:0]       pkt_mask_i,
  input  link_cache_pkg::load_size_e                    pkt_size_i,
  input  logic                                          pkt_unsigned_i,
  input  logic                                          pkt_ifetch_i,
  input  logic [link_cache_pkg::id_width_c-1:0]         pkt_id_i,
  input  logic                                          pkt_v_i,
  output logic                                          pkt_yumi_o,
  output link_cache_pkg::cache_op_e                     cache_op_o,
  output logic [link_cache_pkg::cache_addr_width_c-1:0] cache_addr_o,
  output logic [link_cache_pkg::data_width_c-1:0]       cache_data_o,
  output logic [link_cache_pkg::mask_width_c-1:0]       cache_mask_o,
  output logic                                          cache_v_o,
  input  logic                                          cache_ready_i,
  input  logic [link_cache_pkg::data_width_c-1:0]       rd_data_i,
  input  logic                                          rd_v_i,
  output logic                                          rd_yumi_o,
  input  logic                                          tv_we_i,
  output link_cache_pkg::ret_type_e                     rsp_type_o,
  output logic [link_cache_pkg::data_width_c-1:0]       rsp_data_o,
  output logic [link_cache_pkg::id_width_c-1:0]         rsp_id_o,
  output logic                                          rsp_v_o,
  input  logic                                          rsp_ready_i,
  output logic                                          route_east_o
);
  localparam int lg_sets_lp = $clog2(SETS_P);
  localparam int lg_block_lp = $clog2(BLOCK_WORDS_P);
  localparam int aw_lp = link_cache_pkg::addr_width_c;

  link_cache_pkg::link_state_e state_r, state_n;
  logic [lg_sets_lp:0] sent_r, sent_n, recv_r, recv_n;
  logic route_r, route_n;
  logic [lg_block_lp-1:0] ifetch_cnt_r;
  logic cnt_up, last_beat;

  link_cache_pkg::addr_region_e region;
  link_cache_pkg::cache_op_e dec_op;
  link_cache_pkg::ret_type_e cur_type;
  logic is_store, is_load, is_ifetch;
  logic [1:0] part_sel;
  logic [link_cache_pkg::cache_addr_width_c-1:0] dec_addr, fetch_addr;

  link_cache_pkg::ret_type_e tl_type_r, tv_type_r;
  logic [link_cache_pkg::id_width_c-1:0] tl_id_r, tv_id_r;

  assign is_store = (pkt_op_i == link_cache_pkg::e_store)
                  | (pkt_op_i == link_cache_pkg::e_store_word);
  assign is_load = (pkt_op_i == link_cache_pkg::e_load);
  assign is_ifetch = is_load & pkt_ifetch_i;
  assign last_beat = (ifetch_cnt_r == BLOCK_WORDS_P - 1);

  // byte offset of a narrow load is the lowest set mask bit
  assign part_sel = pkt_mask_i[0] ? 2'd0 : pkt_mask_i[1] ? 2'd1 : pkt_mask_i[2] ? 2'd2 : 2'd3;
  assign fetch_addr = {pkt_addr_i[aw_lp-2:lg_block_lp], ifetch_cnt_r, 2'b00};
  assign dec_addr = is_ifetch ? fetch_addr
                  : {pkt_addr_i[aw_lp-2:0], is_load ? part_sel : 2'b00};

  always_comb begin
    if (pkt_addr_i[aw_lp-1-:2] == 2'b11) region = link_cache_pkg::e_region_route;
    else if (pkt_addr_i[aw_lp-1]) region = link_cache_pkg::e_region_tag;
    else region = link_cache_pkg::e_region_data;

    if (is_store) cur_type = link_cache_pkg::e_ret_credit;
    else if (is_ifetch) cur_type = link_cache_pkg::e_ret_ifetch;
    else cur_type = link_cache_pkg::e_ret_int_wb;

    dec_op = link_cache_pkg::TAGLA;
    if (region == link_cache_pkg::e_region_tag) begin
      dec_op = is_store ? link_cache_pkg::TAGST : link_cache_pkg::TAGLA;
    end else if (region == link_cache_pkg::e_region_data) begin
      case (pkt_op_i)
        link_cache_pkg::e_store, link_cache_pkg::e_store_word: dec_op = link_cache_pkg::SM;
        link_cache_pkg::e_amoswap: dec_op = link_cache_pkg::AMOSWAP_W;
        link_cache_pkg::e_amoor: dec_op = link_cache_pkg::AMOOR_W;
        link_cache_pkg::e_amoadd: dec_op = link_cache_pkg::AMOADD_W;
        default: begin
          if (is_ifetch || pkt_size_i == link_cache_pkg::e_size_word)
            dec_op = link_cache_pkg::LW;
          else if (pkt_size_i == link_cache_pkg::e_size_half)
            dec_op = pkt_unsigned_i ? link_cache_pkg::LHU : link_cache_pkg::LH;
          else
            dec_op = pkt_unsigned_i ? link_cache_pkg::LBU : link_cache_pkg::LB;
        end
      endcase
    end
  end

  always_comb begin
    state_n = state_r;
    sent_n = sent_r;
    recv_n = recv_r;
    route_n = route_r;
    cnt_up = 1'b0;
    cache_v_o = 1'b0;
    cache_op_o = link_cache_pkg::TAGST;
    cache_addr_o = '0;
    cache_data_o = '0;
    cache_mask_o = '0;
    pkt_yumi_o = 1'b0;
    rd_yumi_o = 1'b0;
    rsp_v_o = 1'b0;

    case (state_r)
      link_cache_pkg::e_state_reset: state_n = link_cache_pkg::e_state_clear_tag;
      link_cache_pkg::e_state_clear_tag: begin
        // zero one tag per line, replies are dropped
        cache_v_o = (sent_r != SETS_P);
        cache_addr_o[lg_block_lp+2 +: lg_sets_lp] = sent_r[lg_sets_lp-1:0];
        if (cache_v_o & cache_ready_i) sent_n = sent_r + 1'b1;
        rd_yumi_o = rd_v_i;
        if (rd_v_i) recv_n = recv_r + 1'b1;
        if (sent_r == SETS_P && recv_r == SETS_P) state_n = link_cache_pkg::e_state_ready;
      end
      link_cache_pkg::e_state_ready: begin
        cache_v_o = pkt_v_i;
        cache_op_o = dec_op;
        cache_addr_o = dec_addr;
        cache_data_o = pkt_data_i;
        cache_mask_o = (pkt_op_i == link_cache_pkg::e_store_word) ? '1 : pkt_mask_i;
        pkt_yumi_o = pkt_v_i & cache_ready_i & ~is_ifetch;
        if (pkt_v_i & cache_ready_i) begin
          // route bit follows the no-op into the store
          if (region == link_cache_pkg::e_region_route && is_store) route_n = pkt_data_i[0];
          if (is_ifetch) begin
            cnt_up = 1'b1;
            state_n = link_cache_pkg::e_state_ifetch;
          end
        end
      end
      link_cache_pkg::e_state_ifetch: begin
        cache_v_o = pkt_v_i;
        cache_op_o = link_cache_pkg::LW;
        cache_addr_o = fetch_addr;
        pkt_yumi_o = pkt_v_i & cache_ready_i & last_beat;
        if (pkt_v_i & cache_ready_i) begin
          cnt_up = 1'b1;
          if (last_beat) state_n = link_cache_pkg::e_state_ready;
        end
      end
      default: state_n = link_cache_pkg::e_state_ready;
    endcase

    if (state_r == link_cache_pkg::e_state_ready || state_r == link_cache_pkg::e_state_ifetch) begin
      rsp_v_o = rd_v_i;
      rd_yumi_o = rd_v_i & rsp_ready_i;
    end
  end

  assign rsp_type_o = tv_type_r;
  assign rsp_id_o = tv_id_r;
  assign rsp_data_o = (tv_type_r == link_cache_pkg::e_ret_credit) ? '0 : rd_data_i;
  assign route_east_o = route_r;

  // reply info follows each command through lookup and verify
  always_ff @(posedge clk_i) begin
    if (cache_v_o & cache_ready_i) begin
      tl_type_r <= cur_type;
      tl_id_r <= pkt_id_i;
    end
    if (tv_we_i) begin
      tv_type_r <= tl_type_r;
      tv_id_r <= tl_id_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= link_cache_pkg::e_state_reset;
      sent_r <= '0;
      recv_r <= '0;
      route_r <= 1'b0;
      ifetch_cnt_r <= '0;
    end else begin
      state_r <= state_n;
      sent_r <= sent_n;
      recv_r <= recv_n;
      route_r <= route_n;
      if (cnt_up) ifetch_cnt_r <= ifetch_cnt_r + 1'b1;
    end
  end

endmodule

/* hdl/line_store_pipe.sv */
module line_store_pipe #(
  parameter int SETS_P = 8,
  parameter int BLOCK_WORDS_P = 4
) (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  link_cache_pkg::cache_op_e                     op_i,
  input  logic [link_cache_pkg::cache_addr_width_c-1:0] addr_i,
  input  logic [link_cache_pkg::data_width_c-1:0]       data_i,
  input  logic [link_cache_pkg::mask_width_c-1:0]       mask_i,
  input  logic                                          v_i,
  output logic                                          ready_o,
  output logic [link_cache_pkg::data_width_c-1:0]       data_o,
  output logic                                          v_o,
  input  logic                                          yumi_i,
  output logic                                          tv_we_o
);
  localparam int dw_lp = link_cache_pkg::data_width_c;
  localparam int mw_lp = link_cache_pkg::mask_width_c;
  localparam int tw_lp = link_cache_pkg::tag_width_c;
  localparam int lg_sets_lp = $clog2(SETS_P);
  localparam int lg_block_lp = $clog2(BLOCK_WORDS_P);

  logic [dw_lp-1:0] data_mem [SETS_P*BLOCK_WORDS_P];
  logic [tw_lp-1:0] tag_mem [SETS_P];

  // lookup stage
  logic tl_v_r;
  link_cache_pkg::cache_op_e tl_op_r;
  logic [link_cache_pkg::cache_addr_width_c-1:0] tl_addr_r;
  logic [dw_lp-1:0] tl_data_r;
  logic [mw_lp-1:0] tl_mask_r;

  // verify stage
  logic tv_v_r;
  logic [dw_lp-1:0] tv_data_r;

  logic [lg_sets_lp+lg_block_lp-1:0] word_idx;
  logic [lg_sets_lp-1:0] set_idx;
  logic [dw_lp-1:0] old_word, new_word, result;
  logic [15:0] half_sel;
  logic [7:0] byte_sel;
  logic [mw_lp-1:0] write_mask;
  logic tag_we;

  assign word_idx = tl_addr_r[2 +: lg_sets_lp+lg_block_lp];
  assign set_idx = tl_addr_r[2+lg_block_lp +: lg_sets_lp];
  assign old_word = data_mem[word_idx];
  assign half_sel = tl_addr_r[1] ? old_word[31:16] : old_word[15:0];
  assign byte_sel = old_word[8*tl_addr_r[1:0] +: 8];

  assign ready_o = ~tv_v_r | yumi_i;
  assign tv_we_o = tl_v_r & (~tv_v_r | yumi_i);
  assign v_o = tv_v_r;
  assign data_o = tv_data_r;

  always_comb begin
    new_word = tl_data_r;
    write_mask = '0;
    tag_we = 1'b0;
    result = '0;
    case (tl_op_r)
      link_cache_pkg::LW: result = old_word;
      link_cache_pkg::LH: result = {{16{half_sel[15]}}, half_sel};
      link_cache_pkg::LHU: result = {16'b0, half_sel};
      link_cache_pkg::LB: result = {{24{byte_sel[7]}}, byte_sel};
      link_cache_pkg::LBU: result = {24'b0, byte_sel};
      link_cache_pkg::SM: write_mask = tl_mask_r;
      link_cache_pkg::AMOSWAP_W, link_cache_pkg::AMOOR_W, link_cache_pkg::AMOADD_W: begin
        // atomics hand back the old word
        result = old_word;
        write_mask = '1;
        if (tl_op_r == link_cache_pkg::AMOOR_W) new_word = old_word | tl_data_r;
        if (tl_op_r == link_cache_pkg::AMOADD_W) new_word = old_word + tl_data_r;
      end
      link_cache_pkg::TAGST: tag_we = 1'b1;
      link_cache_pkg::TAGLA: result = {{(dw_lp-tw_lp){1'b0}}, tag_mem[set_idx]};
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (v_i & ready_o) begin
      tl_op_r <= op_i;
      tl_addr_r <= addr_i;
      tl_data_r <= data_i;
      tl_mask_r <= mask_i;
    end
    if (tv_we_o) begin
      for (int b = 0; b < mw_lp; b++) begin
        if (write_mask[b]) data_mem[word_idx][8*b +: 8] <= new_word[8*b +: 8];
      end
      if (tag_we) tag_mem[set_idx] <= tl_data_r[tw_lp-1:0];
      tv_data_r <= result;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_r <= 1'b0;
      tv_v_r <= 1'b0;
    end else begin
      if (v_i & ready_o) tl_v_r <= 1'b1;
      else if (tv_we_o) tl_v_r <= 1'b0;
      if (tv_we_o) tv_v_r <= 1'b1;
      else if (yumi_i) tv_v_r <= 1'b0;
    end
  end

endmodule

/* hdl/link_cache_top.sv */
module link_cache_top #(
  parameter int SETS_P = 8,
  parameter int BLOCK_WORDS_P = 4,
  parameter int FIFO_ELS_P = 4
) (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  link_cache_pkg::net_op_e                 req_op_i,
  input  logic [link_cache_pkg::addr_width_c-1:0] req_addr_i,
  input  logic [link_cache_pkg::data_width_c-1:0] req_data_i,
  input  logic [link_cache_pkg::mask_width_c-1:0] req_mask_i,
  input  link_cache_pkg::load_size_e              req_size_i,
  input  logic                                    req_unsigned_i,
  input  logic                                    req_ifetch_i,
  input  logic [link_cache_pkg::id_width_c-1:0]   req_id_i,
  input  logic                                    req_v_i,
  output logic                                    req_ready_o,
  output link_cache_pkg::ret_type_e               rsp_type_o,
  output logic [link_cache_pkg::data_width_c-1:0] rsp_data_o,
  output logic [link_cache_pkg::id_width_c-1:0]   rsp_id_o,
  output logic                                    rsp_v_o,
  input  logic                                    rsp_ready_i,
  output logic                                    route_east_o
);
  link_cache_pkg::net_op_e pkt_op;
  logic [link_cache_pkg::addr_width_c-1:0] pkt_addr;
  logic [link_cache_pkg::data_width_c-1:0] pkt_data;
  logic [link_cache_pkg::mask_width_c-1:0] pkt_mask;
  link_cache_pkg::load_size_e pkt_size;
  logic pkt_unsigned, pkt_ifetch, pkt_v, pkt_yumi;
  logic [link_cache_pkg::id_width_c-1:0] pkt_id;

  link_cache_pkg::cache_op_e cache_op;
  logic [link_cache_pkg::cache_addr_width_c-1:0] cache_addr;
  logic [link_cache_pkg::data_width_c-1:0] cache_data, rd_data;
  logic [link_cache_pkg::mask_width_c-1:0] cache_mask;
  logic cache_v, cache_ready, rd_v, rd_yumi, tv_we;

  request_fifo #(.FIFO_ELS_P(FIFO_ELS_P)) request_fifo_inst (
    .clk_i, .reset_i,
    .req_op_i, .req_addr_i, .req_data_i, .req_mask_i,
    .req_size_i, .req_unsigned_i, .req_ifetch_i, .req_id_i,
    .v_i(req_v_i), .ready_o(req_ready_o),
    .pkt_op_o(pkt_op), .pkt_addr_o(pkt_addr), .pkt_data_o(pkt_data), .pkt_mask_o(pkt_mask),
    .pkt_size_o(pkt_size), .pkt_unsigned_o(pkt_unsigned), .pkt_ifetch_o(pkt_ifetch),
    .pkt_id_o(pkt_id), .v_o(pkt_v), .yumi_i(pkt_yumi)
  );

  link_to_cache #(.SETS_P(SETS_P), .BLOCK_WORDS_P(BLOCK_WORDS_P)) link_to_cache_inst (
    .clk_i, .reset_i,
    .pkt_op_i(pkt_op), .pkt_addr_i(pkt_addr), .pkt_data_i(pkt_data), .pkt_mask_i(pkt_mask),
    .pkt_size_i(pkt_size), .pkt_unsigned_i(pkt_unsigned), .pkt_ifetch_i(pkt_ifetch),
    .pkt_id_i(pkt_id), .pkt_v_i(pkt_v), .pkt_yumi_o(pkt_yumi),
    .cache_op_o(cache_op), .cache_addr_o(cache_addr), .cache_data_o(cache_data),
    .cache_mask_o(cache_mask), .cache_v_o(cache_v), .cache_ready_i(cache_ready),
    .rd_data_i(rd_data), .rd_v_i(rd_v), .rd_yumi_o(rd_yumi), .tv_we_i(tv_we),
    .rsp_type_o, .rsp_data_o, .rsp_id_o, .rsp_v_o, .rsp_ready_i,
    .route_east_o
  );

  line_store_pipe #(.SETS_P(SETS_P), .BLOCK_WORDS_P(BLOCK_WORDS_P)) line_store_pipe_inst (
    .clk_i, .reset_i,
    .op_i(cache_op), .addr_i(cache_addr), .data_i(cache_data), .mask_i(cache_mask),
    .v_i(cache_v), .ready_o(cache_ready),
    .data_o(rd_data), .v_o(rd_v), .yumi_i(rd_yumi), .tv_we_o(tv_we)
  );

endmodule

/* testbench/link_cache_props.sv */
module link_cache_props #(
  parameter int SETS_P = 8
) (
  input logic                                          clk_i,
  input logic                                          reset_i,
  input logic                                          pkt_v_i,
  input logic                                          pkt_yumi_o,
  input logic                                          cache_v_o,
  input logic                                          cache_ready_i,
  input link_cache_pkg::cache_op_e                     cache_op_o,
  input logic [link_cache_pkg::cache_addr_width_c-1:0] cache_addr_o,
  input logic [link_cache_pkg::data_width_c-1:0]       cache_data_o,
  input logic [$clog2(SETS_P):0]                       sent_cnt_i,
  input logic [$clog2(SETS_P):0]                       recv_cnt_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // a command waiting on the store keeps its fields
  assert property (@(posedge clk_i) disable iff (reset_i)
    cache_v_o && !cache_ready_i |=> cache_v_o && $stable(cache_op_o)
      && $stable(cache_addr_o) && $stable(cache_data_o))
    else $error("cache command changed before cache_ready_i");

  assert property (@(posedge clk_i) disable iff (reset_i) pkt_yumi_o |-> pkt_v_i)
    else $error("pkt_yumi_o raised without pkt_v_i");

  // queue stays untouched until every tag is zeroed
  assert property (@(posedge clk_i) disable iff (reset_i)
    pkt_yumi_o |-> (sent_cnt_i == SETS_P) && (recv_cnt_i == SETS_P))
    else $error("pkt_yumi_o raised before the tag clear finished");

endmodule

bind link_to_cache link_cache_props #(.SETS_P(SETS_P)) link_cache_props_inst (
  .clk_i(clk_i), .reset_i(reset_i), .pkt_v_i(pkt_v_i), .pkt_yumi_o(pkt_yumi_o),
  .cache_v_o(cache_v_o), .cache_ready_i(cache_ready_i), .cache_op_o(cache_op_o),
  .cache_addr_o(cache_addr_o), .cache_data_o(cache_data_o),
  .sent_cnt_i(sent_r), .recv_cnt_i(recv_r)
);

/* testbench/link_cache_tb.sv */
module link_cache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int sets_lp = 8;
  localparam int block_lp = 4;
  localparam int words_lp = sets_lp * block_lp;

  localparam link_cache_pkg::net_op_e op_st = link_cache_pkg::e_store;
  localparam link_cache_pkg::net_op_e op_sw = link_cache_pkg::e_store_word;
  localparam link_cache_pkg::net_op_e op_ld = link_cache_pkg::e_load;
  localparam link_cache_pkg::net_op_e op_swap = link_cache_pkg::e_amoswap;
  localparam link_cache_pkg::net_op_e op_or = link_cache_pkg::e_amoor;
  localparam link_cache_pkg::net_op_e op_add = link_cache_pkg::e_amoadd;
  localparam link_cache_pkg::load_size_e sz_w = link_cache_pkg::e_size_word;
  localparam link_cache_pkg::load_size_e sz_h = link_cache_pkg::e_size_half;
  localparam link_cache_pkg::load_size_e sz_b = link_cache_pkg::e_size_byte;
  localparam link_cache_pkg::ret_type_e rt_cr = link_cache_pkg::e_ret_credit;
  localparam link_cache_pkg::ret_type_e rt_wb = link_cache_pkg::e_ret_int_wb;
  localparam link_cache_pkg::ret_type_e rt_if = link_cache_pkg::e_ret_ifetch;

  typedef struct {
    string name;
    link_cache_pkg::net_op_e op;
    logic [15:0] addr;
    logic [3:0] mask;
    link_cache_pkg::load_size_e size;
    logic uns;
    logic ifetch;
    logic fixed;
    logic [31:0] data;
    link_cache_pkg::ret_type_e rtype;
  } entry_t;

  typedef struct {
    int idx;
    logic first;
    logic last;
    link_cache_pkg::ret_type_e rtype;
    logic [31:0] data;
    logic [5:0] id;
    logic chk_route;
    logic route;
  } reply_t;

  logic clk_i, reset_i;
  link_cache_pkg::net_op_e req_op_i;
  logic [15:0] req_addr_i;
  logic [31:0] req_data_i;
  logic [3:0] req_mask_i;
  link_cache_pkg::load_size_e req_size_i;
  logic req_unsigned_i, req_ifetch_i, req_v_i, req_ready_o;
  logic [5:0] req_id_i, rsp_id_o;
  link_cache_pkg::ret_type_e rsp_type_o;
  logic [31:0] rsp_data_o;
  logic rsp_v_o, rsp_ready_i, route_east_o;

  entry_t table_q[$];
  reply_t exp_q[$];
  logic [31:0] mem_model [words_lp];
  logic [15:0] tag_model [sets_lp];
  int check_count, err_count, entry_err, done_count, cycle_count;

  link_cache_top #(
    .SETS_P(sets_lp), .BLOCK_WORDS_P(block_lp), .FIFO_ELS_P(4)
  ) link_cache_top_inst (.*);

  always #20 clk_i = ~clk_i;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic add_entry(input string name, input link_cache_pkg::net_op_e op,
                           input logic [15:0] addr, input logic [3:0] mask,
                           input link_cache_pkg::load_size_e size, input logic uns,
                           input logic ifetch, input link_cache_pkg::ret_type_e rtype);
    entry_t e;
    e = '{name, op, addr, mask, size, uns, ifetch, 1'b0, 32'h0, rtype};
    table_q.push_back(e);
  endtask

  // route stores carry fixed data and drain before the next request
  task automatic add_route(input string name, input logic [31:0] data);
    entry_t e;
    e = '{name, op_sw, 16'hc000, 4'hf, sz_w, 1'b0, 1'b0, 1'b1, data, rt_cr};
    table_q.push_back(e);
  endtask

  task automatic build_table();
    for (int i = 0; i < sets_lp; i++) begin
      add_entry("tag clear", op_ld, 16'h8000 + 16'(i * block_lp), 4'hf, sz_w,
                1'b0, 1'b0, rt_wb);
    end
    for (int i = 0; i < 16; i++) begin
      add_entry("word store", op_sw, 16'(i), 4'h0, sz_w, 1'b0, 1'b0, rt_cr);
    end
    add_entry("masked store", op_st, 16'd3, 4'b0110, sz_w, 1'b0, 1'b0, rt_cr);
    add_entry("load word", op_ld, 16'd3, 4'hf, sz_w, 1'b0, 1'b0, rt_wb);
    add_entry("load half", op_ld, 16'd3, 4'b0011, sz_h, 1'b0, 1'b0, rt_wb);
    add_entry("load half upper", op_ld, 16'd3, 4'b1100, sz_h, 1'b0, 1'b0, rt_wb);
    add_entry("load half unsigned", op_ld, 16'd3, 4'b1100, sz_h, 1'b1, 1'b0, rt_wb);
    add_entry("load byte", op_ld, 16'd3, 4'b0100, sz_b, 1'b0, 1'b0, rt_wb);
    add_entry("load byte unsigned", op_ld, 16'd3, 4'b1000, sz_b, 1'b1, 1'b0, rt_wb);
    add_entry("load byte low", op_ld, 16'd3, 4'b0001, sz_b, 1'b0, 1'b0, rt_wb);
    add_entry("amoswap", op_swap, 16'd5, 4'hf, sz_w, 1'b0, 1'b0, rt_wb);
    add_entry("load after amoswap", op_ld, 16'd5, 4'hf, sz_w, 1'b0, 1'b0, rt_wb);
    add_entry("amoor", op_or, 16'd6, 4'hf, sz_w, 1'b0, 1'b0, rt_wb);
    add_entry("load after amoor", op_ld, 16'd6, 4'hf, sz_w, 1'b0, 1'b0, rt_wb);
    add_entry("amoadd", op_add, 16'd7, 4'hf, sz_w, 1'b0, 1'b0, rt_wb);
    add_entry("load after amoadd", op_ld, 16'd7, 4'hf, sz_w, 1'b0, 1'b0, rt_wb);
    add_entry("tag store", op_sw, 16'h8008, 4'hf, sz_w, 1'b0, 1'b0, rt_cr);
    add_entry("tag load", op_ld, 16'h8008, 4'hf, sz_w, 1'b0, 1'b0, rt_wb);
    add_entry("tag store mid line", op_st, 16'h8015, 4'h3, sz_w, 1'b0, 1'b0, rt_cr);
    add_entry("tag load line start", op_ld, 16'h8014, 4'hf, sz_w, 1'b0, 1'b0, rt_wb);
    add_entry("ifetch", op_ld, 16'd10, 4'hf, sz_w, 1'b0, 1'b1, rt_if);
    add_entry("ifetch", op_ld, 16'd13, 4'hf, sz_w, 1'b0, 1'b1, rt_if);
    add_route("route east", 32'h1);
    add_route("route west", 32'h0);
    for (int i = 0; i < 8; i++) begin
      add_entry("load word", op_ld, 16'(i), 4'hf, sz_w, 1'b0, 1'b0, rt_wb);
    end
  endtask

  // expected replies in order, memory updated as the request is accepted
  task automatic model_request(input int idx, input entry_t e, input logic [31:0] d);
    reply_t r;
    logic [31:0] w;
    logic [15:0] h;
    logic [7:0] b;
    int wi;
    int line;
    int off;
    wi = int'(e.addr) % words_lp;
    line = wi / block_lp;
    // lowest enabled byte lane picks the narrow load
    off = 0;
    for (int k = 3; k >= 0; k--) begin
      if (e.mask[k]) off = k;
    end
    w = mem_model[wi];
    r = '{idx, 1'b1, 1'b1, e.rtype, 32'h0, 6'(idx), 1'b0, 1'b0};
    if (e.addr[15:14] == 2'b11) begin
      r.chk_route = 1'b1;
      r.route = d[0];
    end else if (e.addr[15]) begin
      if (e.op == op_ld) r.data = {16'h0, tag_model[line]};
      else tag_model[line] = d[15:0];
    end else if (e.ifetch) begin
      for (int k = 0; k < block_lp; k++) begin
        r.first = (k == 0);
        r.last = (k == block_lp - 1);
        r.data = mem_model[line * block_lp + k];
        exp_q.push_back(r);
      end
    end else begin
      h = (off >= 2) ? w[31:16] : w[15:0];
      b = w[8*off +: 8];
      case (e.op)
        op_st: begin
          for (int k = 0; k < 4; k++) begin
            if (e.mask[k]) mem_model[wi][8*k +: 8] = d[8*k +: 8];
          end
        end
        op_sw: mem_model[wi] = d;
        op_swap: mem_model[wi] = d;
        op_or: mem_model[wi] = w | d;
        op_add: mem_model[wi] = w + d;
        default: begin
          if (e.size == sz_h) r.data = e.uns ? {16'h0, h} : {{16{h[15]}}, h};
          else if (e.size == sz_b) r.data = e.uns ? {24'h0, b} : {{24{b[7]}}, b};
          else r.data = w;
        end
      endcase
      if (e.op == op_swap || e.op == op_or || e.op == op_add) r.data = w;
    end
    if (!e.ifetch) exp_q.push_back(r);
  endtask

  initial begin
    logic [31:0] d;
    void'($urandom(49));
    clk_i = 1'b0;
    reset_i = 1'b1;
    req_op_i = op_ld;
    req_addr_i = '0;
    req_data_i = '0;
    req_mask_i = '0;
    req_size_i = sz_w;
    req_unsigned_i = 1'b0;
    req_ifetch_i = 1'b0;
    req_id_i = '0;
    req_v_i = 1'b0;
    rsp_ready_i = 1'b0;
    check_count = 0;
    err_count = 0;
    entry_err = 0;
    done_count = 0;
    cycle_count = 0;
    for (int s = 0; s < sets_lp; s++) tag_model[s] = '0;
    build_table();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    check("req_ready_o", 32'(req_ready_o), 32'h0);
    check("rsp_v_o", 32'(rsp_v_o), 32'h0);
    check("route_east_o", 32'(route_east_o), 32'h0);
    $display("test reset: %s", (err_count == 0) ? "ok" : "mismatch");
    foreach (table_q[i]) begin
      d = table_q[i].fixed ? table_q[i].data : $urandom;
      req_op_i = table_q[i].op;
      req_addr_i = table_q[i].addr;
      req_data_i = d;
      req_mask_i = table_q[i].mask;
      req_size_i = table_q[i].size;
      req_unsigned_i = table_q[i].uns;
      req_ifetch_i = table_q[i].ifetch;
      req_id_i = 6'(i);
      req_v_i = 1'b1;
      do begin
        @(posedge clk_i);
      end while (!req_ready_o);
      model_request(i, table_q[i], d);
      @(negedge clk_i);
      req_v_i = 1'b0;
      while (table_q[i].fixed && exp_q.size() != 0) @(negedge clk_i);
    end
    while (done_count < table_q.size()) @(negedge clk_i);
    // late extra replies show up in the collector
    repeat (20) @(negedge clk_i);
    $display("%0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  always @(negedge clk_i) begin
    if (!reset_i) rsp_ready_i = ($urandom % 4) != 0;
  end

  always @(posedge clk_i) begin
    reply_t r;
    if (!reset_i && rsp_v_o && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("reply with id %h arrived with no request outstanding", rsp_id_o);
        err_count++;
      end else begin
        r = exp_q.pop_front();
        if (r.first) entry_err = err_count;
        check("rsp_type_o", 32'(rsp_type_o), 32'(r.rtype));
        check("rsp_data_o", rsp_data_o, r.data);
        check("rsp_id_o", 32'(rsp_id_o), 32'(r.id));
        if (r.chk_route) check("route_east_o", 32'(route_east_o), 32'(r.route));
        if (r.last) begin
          $display("test %0d %s: %s", r.idx, table_q[r.idx].name,
                   (err_count == entry_err) ? "ok" : "mismatch");
          done_count++;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > 40 * table_q.size() + 200) begin
      $display("timeout after %0d cycles, %0d of %0d tests finished", cycle_count,
               done_count, table_q.size());
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

endmodule

/* link_cache_top.f */
hdl/link_cache_pkg.sv
hdl/request_fifo.sv
hdl/link_to_cache.sv
hdl/line_store_pipe.sv
hdl/link_cache_top.sv
testbench/link_cache_props.sv
testbench/link_cache_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module link_cache_tb -f link_cache_top.f -o link_cache_sim

./obj_dir/link_cache_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
  exit 0
fi
exit 1
